// File: player_ctrl.f
rtl/game_geom_pkg.sv
rtl/player_pkg.sv
rtl/contact_sense.sv
rtl/motion_fsm.sv
rtl/motion_datapath.sv
rtl/sprite_select.sv
rtl/player_ctrl.sv
bench/clk_gen.sv
bench/player_ctrl_asserts.sv
bench/player_ctrl_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= player_ctrl_tb
FILELIST   ?= player_ctrl.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
FAIL_MSG   := STATUS: FAIL

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/player_ctrl_tb.sv
`timescale 1ns/1ps

module player_ctrl_tb
    import game_geom_pkg::*, player_pkg::*;
();

    localparam int WALK = 5, CLIMB = 3, JUMP = 50, GRAV = 3;
    localparam int T1_LEN = 10, T2_LEN = 80, T3_LEN = 150, T4_LEN = 400;
    localparam int T5_LEN = 60, T6_LEN = 420;
    localparam int CYCLE_LIMIT = T1_LEN + T2_LEN + T3_LEN + T4_LEN + T5_LEN + T6_LEN + 200;

    logic clk, rst, rst_gen, rst_force, start, over;
    key_t keys;
    pose_t pose;
    player_state_t state;
    frame_t frame;

    // model of the controller
    player_state_t m_state;
    int m_x, m_y, m_vx, m_vy, m_cnt;
    bit m_face, model_ok;

    string test_name;
    int errors, test_errors, tests_run, tests_failed, cycles;

    assign rst = rst_gen | rst_force;

    clk_gen #(.PERIOD(100ns)) u_clk (.clk(clk), .rst(rst_gen));

    player_ctrl #(.WALK_SPEED(WALK), .CLIMB_SPEED(CLIMB), .JUMP_SPEED(JUMP), .GRAVITY(GRAV))
    uut (.clk(clk), .rst(rst), .start(start), .over(over), .keys(keys),
         .pose(pose), .state(state), .frame(frame));

    bind player_ctrl player_ctrl_asserts u_asserts (.clk(clk), .rst(rst), .pose(pose),
                                                   .state(state));

    function automatic bit ground_at(int x, int y);
        bit g;
        g = (y + 36 >= 461);
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (x < int'(PLATFORMS[i].rx) && x + 34 > int'(PLATFORMS[i].lx)
                && y + 36 >= int'(PLATFORMS[i].ly) && y + 36 <= int'(PLATFORMS[i].ry))
                g = 1;
        end
        return g;
    endfunction

    function automatic bit ladder_at(int x, int y);
        bit l;
        l = 0;
        for (int i = 0; i < NUM_LADDERS; i++) begin
            if (x >= int'(LADDERS[i].lx) && x <= int'(LADDERS[i].rx)
                && y > int'(LADDERS[i].ly) && y < int'(LADDERS[i].ry))
                l = 1;
        end
        return l;
    endfunction

    function automatic int lim(int v, int lo, int hi);
        return v < lo ? lo : (v > hi ? hi : v);
    endfunction

    function automatic frame_t expected_frame(player_state_t st, int cnt, bit face,
                                              bit mright, key_t k);
        int ph;
        ph = (cnt >> 3) & 3;
        case (st)
            ST_FLYING: return face ? FLY_LEFT : FLY_RIGHT;
            ST_WALKING: begin
                if (ph == 0) return mright ? WALK_RIGHT1 : WALK_LEFT1;
                if (ph == 2) return mright ? WALK_RIGHT2 : WALK_LEFT2;
                return mright ? WALK_RIGHT3 : WALK_LEFT3;
            end
            ST_DYING: begin
                case ((cnt >> 1) & 3)
                    0: return DIE1;
                    1: return DIE2;
                    2: return DIE3;
                    default: return DIE4;
                endcase
            end
            ST_CLIMBING: return ((k.up | k.down) && ((cnt >> 2) & 1)) ? CLAMP2 : CLAMP1;
            default: return face ? WALK_LEFT3 : WALK_RIGHT3;
        endcase
    endfunction

    // one game step of the model from the inputs seen at the edge
    function void model_step();
        player_state_t ns;
        bit g, l, land;
        int dx, dy, ny, nx;
        if (rst) begin
            m_state = ST_INITIAL;
            m_x = START_X;
            m_y = START_Y;
            m_vx = 0;
            m_vy = 0;
            m_face = 1;
            m_cnt = 0;
            model_ok = 1;
            return;
        end
        g = ground_at(m_x, m_y);
        l = ladder_at(m_x, m_y);
        ns = m_state;
        if (m_state != ST_INITIAL && over) ns = ST_DYING;
        else case (m_state)
            ST_INITIAL: if (start) ns = ST_STANDING;
            ST_STANDING, ST_WALKING: begin
                if (!g) ns = ST_FLYING;
                else if (keys.jump) ns = ST_JUMPING;
                else if ((keys.up | keys.down) && l) ns = ST_CLIMBING;
                else if (m_state == ST_STANDING && (keys.left | keys.right)) ns = ST_WALKING;
                else if (m_state == ST_WALKING && !(keys.left | keys.right)) ns = ST_STANDING;
            end
            ST_JUMPING: ns = ST_FLYING;
            ST_FLYING: if (g && m_vy >= 0) ns = ST_STANDING;
            ST_CLIMBING: begin
                if (g && keys.jump) ns = ST_JUMPING;
                else if (keys.left | keys.right) ns = ST_WALKING;
                else if (!l) ns = ST_STANDING;
            end
            default: ;
        endcase
        case (m_state)
            ST_INITIAL: begin
                m_x = START_X;
                m_y = START_Y;
            end
            ST_WALKING: begin
                dx = keys.left ? -WALK : WALK;
                m_vx = dx;
                m_vy = 0;
                m_x = lim(m_x + dx, 5, 606);
                m_cnt = (m_cnt + 1) % 32;
                if (keys.left) m_face = 1;
                else if (keys.right) m_face = 0;
            end
            ST_JUMPING: m_vy = -JUMP;
            ST_FLYING: begin
                dy = m_vy / 10;
                ny = m_y + dy;
                nx = lim(m_x + m_vx, 5, 606);
                land = 0;
                for (int i = 0; i < NUM_PLATFORMS; i++) begin
                    if (!land && dy > 0 && m_y + 36 <= int'(PLATFORMS[i].ly)
                        && ny + 36 >= int'(PLATFORMS[i].ly)
                        && nx < int'(PLATFORMS[i].rx) && nx + 34 > int'(PLATFORMS[i].lx)) begin
                        land = 1;
                        ny = int'(PLATFORMS[i].ly) - 36;
                    end
                end
                m_x = nx;
                m_y = land ? ny : lim(ny, 5, 425);
                m_vy = land ? 0 : m_vy + GRAV;
                m_cnt = (m_cnt + 1) % 32;
            end
            ST_CLIMBING: begin
                m_vx = 0;
                m_vy = 0;
                if (keys.up | keys.down) begin
                    m_y = lim(keys.up ? m_y - CLIMB : m_y + CLIMB, 5, 425);
                    m_cnt = (m_cnt + 1) % 32;
                end
            end
            ST_STANDING, ST_DYING: begin
                m_vx = 0;
                m_vy = 0;
            end
            default: ;
        endcase
        m_state = ns;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("ERROR %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            errors++;
        end
    endtask

    always @(posedge clk) model_step();

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (model_ok) begin
            check("state", m_state, state);
            check("x", m_x, pose.x);
            check("y", m_y, pose.y);
            check("frame", expected_frame(m_state, m_cnt, m_face, m_vx > 0, keys), frame);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("run exceeded its cycle limit of %0d", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic step(input int n = 1);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_state(input player_state_t target, input int limit);
        int n;
        n = 0;
        while (state != target && n < limit) begin
            step();
            n++;
        end
        if (state != target) begin
            $display("%s: state %s never reached within %0d cycles", test_name,
                     target.name(), limit);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_errors) tests_failed++;
        $display("test %s: %s", test_name, errors == test_errors ? "ok" : "failed");
    endtask

    initial begin
        pose_t frozen;
        int n, hold;
        bit [31:0] seed;
        seed = 32'h9ffc_741d;
        void'($urandom(seed));
        {rst_force, start, over, keys, errors, tests_run, tests_failed, cycles} = '0;
        model_ok = 0;
        @(negedge rst_gen);

        begin_test("reset_start");
        check("state", ST_INITIAL, state);
        check("frame", WALK_LEFT3, frame);
        start = 1;
        step();
        check("state", ST_STANDING, state);
        end_test();

        begin_test("walk_right");
        keys.right = 1;
        n = 0;
        while (pose.x != RIGHT_BOUND - SPRITE_W && n < T2_LEN - 10) begin
            step();
            n++;
        end
        check("clamp_x", RIGHT_BOUND - SPRITE_W, pose.x);
        keys.right = 0;
        wait_state(ST_STANDING, 5);
        end_test();

        begin_test("jump");
        keys.jump = 1;
        step();
        keys.jump = 0;
        wait_state(ST_FLYING, 5);
        wait_state(ST_STANDING, T3_LEN);
        check("land_y", BOTTOM_BOUND - SPRITE_H, pose.y);
        end_test();

        begin_test("ladder");
        keys.left = 1;
        n = 0;
        // the release step moves right once, so stop that far inside the column
        while (pose.x > LADDERS[4].rx - WALK && n < 150) begin
            step();
            n++;
        end
        keys.left = 0;
        keys.up = 1;
        wait_state(ST_CLIMBING, 5);
        n = 0;
        while (state == ST_CLIMBING && n < 100) begin
            step();
            n++;
        end
        keys.up = 0;
        wait_state(ST_STANDING, 150);
        end_test();

        begin_test("over");
        keys.right = 1;
        step(4);
        over = 1;
        wait_state(ST_DYING, 3);
        frozen = pose;
        keys = '0;
        step(20);
        over = 0;
        step(4);
        check("dying", ST_DYING, state);
        check("frozen", frozen, pose);
        rst_force = 1;
        step(2);
        rst_force = 0;
        check("reset", ST_INITIAL, state);
        wait_state(ST_STANDING, 3);
        end_test();

        begin_test("random");
        n = 0;
        while (n < T6_LEN - 20) begin
            keys = key_t'($urandom_range(0, 31));
            hold = $urandom_range(1, 16);
            step(hold);
            n += hold;
        end
        keys = '0;
        step(2);
        end_test();

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/player_ctrl_asserts.sv
`timescale 1ns/1ps

module player_ctrl_asserts
    import game_geom_pkg::*, player_pkg::*;
(
    input logic          clk,
    input logic          rst,
    input pose_t         pose,
    input player_state_t state
);

    a_reset_initial: assert property (@(posedge clk) rst |=> state == ST_INITIAL)
        else $error("state not initial after reset");

    a_jump_then_fly: assert property (@(posedge clk) disable iff (rst)
        state == ST_JUMPING |=> (state == ST_FLYING || state == ST_DYING))
        else $error("jumping not followed by flying or dying");

    a_pose_bounds: assert property (@(posedge clk) disable iff (rst)
        pose.x >= LEFT_BOUND && pose.x <= RIGHT_BOUND - SPRITE_W
        && pose.y >= TOP_BOUND && pose.y <= BOTTOM_BOUND - SPRITE_H)
        else $error("pose left the playfield");

endmodule

// File: bench/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter time PERIOD = 100ns
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset held over the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: rtl/player_ctrl.sv
`timescale 1ns/1ps

module player_ctrl
    import player_pkg::*;
#(
    parameter int WALK_SPEED  = 5,
    parameter int CLIMB_SPEED = 3,
    parameter int JUMP_SPEED  = 50,
    parameter int GRAVITY     = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          over,
    input  key_t          keys,
    output pose_t         pose,
    output player_state_t state,
    output frame_t        frame
);

    contact_t   contact;
    logic       falling;
    logic       facing_left;
    logic       moving_right;
    logic [4:0] anim_count;

    contact_sense u_contact (
        .pose    (pose),
        .contact (contact)
    );

    motion_fsm u_fsm (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .over    (over),
        .keys    (keys),
        .contact (contact),
        .falling (falling),
        .state   (state)
    );

    motion_datapath #(
        .WALK_SPEED  (WALK_SPEED),
        .CLIMB_SPEED (CLIMB_SPEED),
        .JUMP_SPEED  (JUMP_SPEED),
        .GRAVITY     (GRAVITY)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .keys         (keys),
        .pose         (pose),
        .falling      (falling),
        .facing_left  (facing_left),
        .moving_right (moving_right),
        .anim_count   (anim_count)
    );

    sprite_select u_sprite (
        .state        (state),
        .anim_count   (anim_count),
        .facing_left  (facing_left),
        .moving_right (moving_right),
        .keys         (keys),
        .frame        (frame)
    );

endmodule

// File: rtl/sprite_select.sv
`timescale 1ns/1ps

module sprite_select
    import player_pkg::*;
(
    input  player_state_t state,
    input  logic [4:0]    anim_count,
    input  logic          facing_left,
    input  logic          moving_right,
    input  key_t          keys,
    output frame_t        frame
);

    // walk cycle 1, 3, 2, 3
    function automatic frame_t walk_frame(input logic right, input logic [1:0] phase);
        case (phase)
            2'd0:    return right ? WALK_RIGHT1 : WALK_LEFT1;
            2'd2:    return right ? WALK_RIGHT2 : WALK_LEFT2;
            default: return right ? WALK_RIGHT3 : WALK_LEFT3;
        endcase
    endfunction

    always_comb begin
        case (state)
            ST_FLYING: begin
                frame = facing_left ? FLY_LEFT : FLY_RIGHT;
            end
            ST_WALKING: begin
                frame = walk_frame(moving_right, anim_count[4:3]);
            end
            ST_DYING: begin
                case (anim_count[2:1])
                    2'd0:    frame = DIE1;
                    2'd1:    frame = DIE2;
                    2'd2:    frame = DIE3;
                    default: frame = DIE4;
                endcase
            end
            ST_CLIMBING: begin
                // idle on the ladder shows the first pose
                if ((keys.up | keys.down) && anim_count[2]) frame = CLAMP2;
                else frame = CLAMP1;
            end
            default: begin
                frame = facing_left ? WALK_LEFT3 : WALK_RIGHT3;
            end
        endcase
    end

endmodule

// File: rtl/motion_datapath.sv
`timescale 1ns/1ps

module motion_datapath
    import game_geom_pkg::*, player_pkg::*;
#(
    parameter int WALK_SPEED  = 5,
    parameter int CLIMB_SPEED = 3,
    parameter int JUMP_SPEED  = 50,
    parameter int GRAVITY     = 3
) (
    input  logic          clk,
    input  logic          rst,
    input  player_state_t state,
    input  key_t          keys,
    output pose_t         pose,
    output logic          falling,
    output logic          facing_left,
    output logic          moving_right,
    output logic [4:0]    anim_count
);

    localparam logic signed [11:0] X_MIN = 12'(LEFT_BOUND);
    localparam logic signed [11:0] X_MAX = 12'(RIGHT_BOUND - SPRITE_W);
    localparam logic signed [12:0] Y_MIN = 13'(TOP_BOUND);
    localparam logic signed [12:0] Y_MAX = 13'(BOTTOM_BOUND - SPRITE_H);

    logic signed [10:0] vel_x;
    vel_y_t             vel_y;
    logic signed [10:0] walk_dx;
    vel_y_t             fly_dy;
    logic signed [12:0] fly_ny;
    logic signed [12:0] feet_now;
    logic signed [12:0] feet_next;
    logic signed [12:0] climb_ny;
    coord_x_t           walk_x;
    coord_x_t           fly_x;
    coord_y_t           fly_y;
    coord_y_t           climb_y;
    logic               land_hit;
    logic               climb_move;

    function automatic coord_x_t clamp_x(input coord_x_t x, input logic signed [10:0] dx);
        logic signed [11:0] nx;
        nx = $signed({2'b00, x}) + 12'(dx);
        if (nx < X_MIN) return LEFT_BOUND;
        else if (nx > X_MAX) return coord_x_t'(X_MAX);
        else return coord_x_t'(nx);
    endfunction

    function automatic coord_y_t clamp_y(input logic signed [12:0] ny);
        if (ny < Y_MIN) return TOP_BOUND;
        else if (ny > Y_MAX) return coord_y_t'(Y_MAX);
        else return coord_y_t'(ny);
    endfunction

    assign walk_dx    = keys.left ? 11'(-WALK_SPEED) : 11'(WALK_SPEED);
    assign walk_x     = clamp_x(pose.x, walk_dx);
    assign fly_x      = clamp_x(pose.x, vel_x);

    // division truncates toward zero
    assign fly_dy     = vel_y / 13'sd10;
    assign fly_ny     = $signed({4'b0000, pose.y}) + fly_dy;
    assign feet_now   = $signed({4'b0000, pose.y}) + 13'(SPRITE_H);
    assign feet_next  = fly_ny + 13'(SPRITE_H);

    assign climb_move = keys.up | keys.down;
    assign climb_ny   = keys.up ? $signed({4'b0000, pose.y}) - 13'(CLIMB_SPEED)
                                : $signed({4'b0000, pose.y}) + 13'(CLIMB_SPEED);
    assign climb_y    = clamp_y(climb_ny);

    // feet crossing a platform top on the way down
    always_comb begin
        land_hit = 1'b0;
        fly_y    = clamp_y(fly_ny);
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (!land_hit && fly_dy > 0
                && feet_now <= $signed(13'(PLATFORMS[i].ly))
                && feet_next >= $signed(13'(PLATFORMS[i].ly))
                && fly_x < PLATFORMS[i].rx
                && fly_x + SPRITE_W > PLATFORMS[i].lx) begin
                land_hit = 1'b1;
                fly_y    = PLATFORMS[i].ly - SPRITE_H;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pose        <= '{x: START_X, y: START_Y};
            vel_x       <= '0;
            vel_y       <= '0;
            facing_left <= 1'b1;
            anim_count  <= '0;
        end else begin
            case (state)
                ST_INITIAL: begin
                    pose <= '{x: START_X, y: START_Y};
                end
                ST_WALKING: begin
                    vel_x      <= walk_dx;
                    vel_y      <= '0;
                    pose.x     <= walk_x;
                    anim_count <= anim_count + 5'd1;
                    if (keys.left) facing_left <= 1'b1;
                    else if (keys.right) facing_left <= 1'b0;
                end
                ST_JUMPING: begin
                    vel_y <= -vel_y_t'(JUMP_SPEED);
                end
                ST_FLYING: begin
                    pose       <= '{x: fly_x, y: fly_y};
                    vel_y      <= land_hit ? vel_y_t'(0) : vel_y + vel_y_t'(GRAVITY);
                    anim_count <= anim_count + 5'd1;
                end
                ST_CLIMBING: begin
                    vel_x <= '0;
                    vel_y <= '0;
                    if (climb_move) begin
                        pose.y     <= climb_y;
                        anim_count <= anim_count + 5'd1;
                    end
                end
                ST_STANDING, ST_DYING: begin
                    vel_x <= '0;
                    vel_y <= '0;
                end
                default: ;
            endcase
        end
    end

    assign falling      = (vel_y >= 0);
    assign moving_right = (vel_x > 0);

endmodule

// File: rtl/motion_fsm.sv
`timescale 1ns/1ps

module motion_fsm
    import player_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          over,
    input  key_t          keys,
    input  contact_t      contact,
    input  logic          falling,
    output player_state_t state
);

    player_state_t next_state;
    logic          side_key;
    logic          climb_req;

    assign side_key  = keys.left | keys.right;
    assign climb_req = (keys.up | keys.down) & contact.on_ladder;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_INITIAL;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        if (state != ST_INITIAL && over) begin
            next_state = ST_DYING;
        end else begin
            case (state)
                ST_INITIAL: begin
                    if (start) next_state = ST_STANDING;
                end
                ST_STANDING, ST_WALKING: begin
                    if (!contact.on_ground) next_state = ST_FLYING;
                    else if (keys.jump) next_state = ST_JUMPING;
                    else if (climb_req) next_state = ST_CLIMBING;
                    else if (state == ST_STANDING && side_key) next_state = ST_WALKING;
                    else if (state == ST_WALKING && !side_key) next_state = ST_STANDING;
                end
                ST_JUMPING: begin
                    next_state = ST_FLYING;
                end
                ST_FLYING: begin
                    // only land on the way down
                    if (contact.on_ground && falling) next_state = ST_STANDING;
                end
                ST_CLIMBING: begin
                    if (contact.on_ground && keys.jump) next_state = ST_JUMPING;
                    else if (side_key) next_state = ST_WALKING;
                    else if (!contact.on_ladder) next_state = ST_STANDING;
                end
                ST_DYING: begin
                    next_state = ST_DYING;
                end
                default: begin
                    next_state = ST_INITIAL;
                end
            endcase
        end
    end

endmodule

// File: rtl/contact_sense.sv
`timescale 1ns/1ps

module contact_sense
    import game_geom_pkg::*, player_pkg::*;
(
    input  pose_t    pose,
    output contact_t contact
);

    logic [9:0] feet;
    logic [9:0] right_edge;
    logic       ground_hit;
    logic       ladder_hit;

    assign feet       = 10'(pose.y) + 10'(SPRITE_H);
    assign right_edge = pose.x + SPRITE_W;

    // feet resting on a platform, or at the floor line
    always_comb begin
        ground_hit = (feet >= 10'(BOTTOM_BOUND));
        for (int i = 0; i < NUM_PLATFORMS; i++) begin
            if (pose.x < PLATFORMS[i].rx
                && right_edge > PLATFORMS[i].lx
                && feet >= 10'(PLATFORMS[i].ly)
                && feet <= 10'(PLATFORMS[i].ry)) begin
                ground_hit = 1'b1;
            end
        end
    end

    // left edge inside the ladder column, y strictly inside
    always_comb begin
        ladder_hit = 1'b0;
        for (int i = 0; i < NUM_LADDERS; i++) begin
            if (pose.x >= LADDERS[i].lx
                && pose.x <= LADDERS[i].rx
                && pose.y > LADDERS[i].ly
                && pose.y < LADDERS[i].ry) begin
                ladder_hit = 1'b1;
            end
        end
    end

    assign contact.on_ground = ground_hit;
    assign contact.on_ladder = ladder_hit;

endmodule

// File: rtl/player_pkg.sv
package player_pkg;

    typedef enum logic [2:0] {
        ST_INITIAL  = 3'b000,
        ST_FLYING   = 3'b001,
        ST_JUMPING  = 3'b010,
        ST_WALKING  = 3'b011,
        ST_STANDING = 3'b100,
        ST_DYING    = 3'b101,
        ST_CLIMBING = 3'b110
    } player_state_t;

    typedef enum logic [3:0] {
        STAND       = 4'b0000,
        WALK_LEFT1  = 4'b0001,
        WALK_LEFT2  = 4'b0010,
        WALK_LEFT3  = 4'b0011,
        WALK_RIGHT1 = 4'b0100,
        WALK_RIGHT2 = 4'b0101,
        FLY_LEFT    = 4'b0110,
        FLY_RIGHT   = 4'b0111,
        CLAMP1      = 4'b1000,
        CLAMP2      = 4'b1001,
        DIE1        = 4'b1010,
        DIE2        = 4'b1011,
        DIE3        = 4'b1100,
        DIE4        = 4'b1101,
        WALK_RIGHT3 = 4'b1110
    } frame_t;

    // up sits in bit 0, jump in bit 4
    typedef struct packed {
        logic jump;
        logic down;
        logic right;
        logic left;
        logic up;
    } key_t;

    typedef struct packed {
        game_geom_pkg::coord_x_t x;
        game_geom_pkg::coord_y_t y;
    } pose_t;

    typedef struct packed {
        logic on_ground;
        logic on_ladder;
    } contact_t;

    // tenths of a pixel per step
    typedef logic signed [12:0] vel_y_t;

endpackage

// File: rtl/game_geom_pkg.sv
package game_geom_pkg;

    typedef logic [9:0] coord_x_t;
    typedef logic [8:0] coord_y_t;

    // playfield limits
    localparam coord_y_t TOP_BOUND    = 9'd5;
    localparam coord_y_t BOTTOM_BOUND = 9'd461;
    localparam coord_x_t LEFT_BOUND   = 10'd5;
    localparam coord_x_t RIGHT_BOUND  = 10'd640;

    // character box
    localparam coord_x_t SPRITE_W = 10'd34;
    localparam coord_y_t SPRITE_H = 9'd36;

    localparam coord_x_t START_X = 10'd450;
    localparam coord_y_t START_Y = 9'd425;

    typedef struct packed {
        coord_x_t lx;
        coord_y_t ly;
        coord_x_t rx;
        coord_y_t ry;
    } rect_t;

    localparam int NUM_PLATFORMS = 6;

    // top to bottom, the last one is the floor
    localparam rect_t PLATFORMS [NUM_PLATFORMS] = '{
        '{10'd250, 9'd53,  10'd388, 9'd70},
        '{10'd0,   9'd115, 10'd591, 9'd131},
        '{10'd49,  9'd197, 10'd640, 9'd213},
        '{10'd0,   9'd286, 10'd591, 9'd302},
        '{10'd49,  9'd376, 10'd640, 9'd393},
        '{10'd0,   9'd461, 10'd640, 9'd479}
    };

    localparam int NUM_LADDERS = 5;

    localparam rect_t LADDERS [NUM_LADDERS] = '{
        '{10'd339, 9'd15,  10'd353, 9'd81},
        '{10'd541, 9'd77,  10'd555, 9'd163},
        '{10'd48,  9'd159, 10'd62,  9'd252},
        '{10'd546, 9'd248, 10'd560, 9'd342},
        '{10'd53,  9'd338, 10'd67,  9'd427}
    };

endpackage
